//--- source/ddr_pkg.sv
// DDR line cache package with shared widths, app address constants and enums
package ddr_pkg;

    // ------------------------------
    // Wishbone side
    // ------------------------------
    localparam int wb_adr_w = 24;
    localparam int wb_dat_w = 32;
    localparam int sel_w = wb_dat_w / 8;

    // ------------------------------
    // Line geometry
    // ------------------------------
    localparam int line_words = 8;
    localparam int word_bits = 3;
    localparam int line_w = line_words * wb_dat_w;
    // Tag is the word address without the word index
    localparam int tag_w = wb_adr_w - word_bits;

    // ------------------------------
    // App interface
    // ------------------------------
    localparam int app_addr_w = 27;
    localparam int app_data_w = 128;
    // One 256-bit line spans 32 app address units
    localparam int line_shift = 5;
    localparam logic [app_addr_w-1:0] beat_offset = 27'd16;

    // App command encodings
    typedef enum logic [2:0] {
        cmd_write = 3'd0,
        cmd_read  = 3'd1
    } app_cmd_t;

    // Line FSM states
    typedef enum logic [2:0] {
        st_init,
        st_idle,
        st_hit,
        st_wb_issue,
        st_wb_wait,
        st_fill_issue,
        st_fill_wait
    } fsm_state_t;

endpackage

//--- source/line_fsm.sv
`timescale 1ns/1ps
// Line FSM sequencing calibration wait, hit service, write-back and line fill
module line_fsm (
    input  logic              ui_clk,
    input  logic              rst,
    input  logic              init_calib_complete,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic              hit,
    input  logic              dirty,
    input  logic              cmd_accept,
    input  logic              wdf_accept,
    input  logic              cmds_done,
    input  logic              wdata_done,
    input  logic              rdata_done,
    output logic              wb_ack,
    output logic              issue_beat,
    output ddr_pkg::app_cmd_t issue_cmd,
    output logic              beat_sel,
    output logic              timer_clear,
    output logic              wr_word,
    output logic              set_valid_clean,
    output logic              set_dirty,
    output logic              use_victim_tag
);

    ddr_pkg::fsm_state_t state;
    ddr_pkg::fsm_state_t state_next;
    logic beat_q;
    logic beat_next;
    logic cmd_seen;
    logic wdf_seen;
    logic beat_cmd_ok;
    logic beat_wdf_ok;
    logic req;

    assign req = wb_cyc & wb_stb;

    // Beat held in app_port has gone out (sticky or this cycle)
    assign beat_cmd_ok = cmd_seen | cmd_accept;
    assign beat_wdf_ok = wdf_seen | wdf_accept;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        beat_next = beat_q;
        case (state)
            ddr_pkg::st_init: begin
                if (init_calib_complete) begin
                    state_next = ddr_pkg::st_idle;
                end
            end
            ddr_pkg::st_idle: begin
                if (req) begin
                    beat_next = 1'b0;
                    if (hit) begin
                        state_next = ddr_pkg::st_hit;
                    end else if (dirty) begin
                        state_next = ddr_pkg::st_wb_issue;
                    end else begin
                        state_next = ddr_pkg::st_fill_issue;
                    end
                end
            end
            ddr_pkg::st_hit: begin
                state_next = ddr_pkg::st_idle;
            end
            ddr_pkg::st_wb_issue: begin
                state_next = ddr_pkg::st_wb_wait;
            end
            ddr_pkg::st_wb_wait: begin
                if (!beat_q) begin
                    // Second beat only once the first left app_port
                    if (beat_cmd_ok && beat_wdf_ok) begin
                        beat_next = 1'b1;
                        state_next = ddr_pkg::st_wb_issue;
                    end
                end else if (cmds_done && wdata_done) begin
                    beat_next = 1'b0;
                    state_next = ddr_pkg::st_fill_issue;
                end
            end
            ddr_pkg::st_fill_issue: begin
                state_next = ddr_pkg::st_fill_wait;
            end
            ddr_pkg::st_fill_wait: begin
                if (!beat_q) begin
                    if (beat_cmd_ok) begin
                        beat_next = 1'b1;
                        state_next = ddr_pkg::st_fill_issue;
                    end
                end else if (rdata_done) begin
                    // Request is replayed from idle as a hit
                    beat_next = 1'b0;
                    state_next = ddr_pkg::st_idle;
                end
            end
            default: begin
                state_next = ddr_pkg::st_init;
            end
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign wb_ack = (state == ddr_pkg::st_hit) & req;
    assign wr_word = (state == ddr_pkg::st_hit) & req & wb_we;
    assign set_dirty = (state == ddr_pkg::st_hit) & req & wb_we;
    assign issue_beat = (state == ddr_pkg::st_wb_issue) | (state == ddr_pkg::st_fill_issue);
    assign issue_cmd = (state == ddr_pkg::st_wb_issue) ? ddr_pkg::cmd_write : ddr_pkg::cmd_read;
    assign beat_sel = beat_q;
    assign use_victim_tag = (state == ddr_pkg::st_wb_issue) | (state == ddr_pkg::st_wb_wait);
    assign set_valid_clean = (state == ddr_pkg::st_fill_wait) & beat_q & rdata_done;

    // Counters restart in idle and again before the first read beat
    assign timer_clear = (state == ddr_pkg::st_idle) |
                         ((state == ddr_pkg::st_fill_issue) & ~beat_q);

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= ddr_pkg::st_init;
            beat_q <= 1'b0;
            cmd_seen <= 1'b0;
            wdf_seen <= 1'b0;
        end else begin
            state <= state_next;
            beat_q <= beat_next;
            if (issue_beat) begin
                cmd_seen <= 1'b0;
                wdf_seen <= 1'b0;
            end else begin
                if (cmd_accept) begin
                    cmd_seen <= 1'b1;
                end
                if (wdf_accept) begin
                    wdf_seen <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/beat_timer.sv
`timescale 1ns/1ps
// Beat timer counting accepted commands, accepted write beats and read returns
module beat_timer (
    input  logic ui_clk,
    input  logic rst,
    input  logic timer_clear,
    input  logic cmd_accept,
    input  logic wdf_accept,
    input  logic app_rd_data_valid,
    output logic cmds_done,
    output logic wdata_done,
    output logic rdata_done,
    output logic rd_beat
);

    logic [1:0] cmd_cnt;
    logic [1:0] wdf_cnt;
    logic [1:0] rd_cnt;

    // Saturates at the two beats of a line
    function automatic logic [1:0] sat_inc(input logic [1:0] cnt, input logic ev);
        if (ev && (cnt != 2'd2)) begin
            return cnt + 2'd1;
        end
        return cnt;
    endfunction

    always_ff @(posedge ui_clk) begin
        if (!rst || timer_clear) begin
            cmd_cnt <= 2'd0;
            wdf_cnt <= 2'd0;
            rd_cnt <= 2'd0;
        end else begin
            cmd_cnt <= sat_inc(cmd_cnt, cmd_accept);
            wdf_cnt <= sat_inc(wdf_cnt, wdf_accept);
            rd_cnt <= sat_inc(rd_cnt, app_rd_data_valid);
        end
    end

    assign cmds_done = (cmd_cnt == 2'd2);
    assign wdata_done = (wdf_cnt == 2'd2);
    assign rdata_done = (rd_cnt == 2'd2);

    // Reads come back in order, so the count names the half
    assign rd_beat = rd_cnt[0];

endmodule

//--- source/line_buffer.sv
`timescale 1ns/1ps
// Line buffer holding one 256-bit line with its tag, valid and dirty state
module line_buffer (
    input  logic                             ui_clk,
    input  logic                             rst,
    input  logic [ddr_pkg::wb_adr_w-1:0]     wb_adr,
    input  logic [ddr_pkg::sel_w-1:0]        wb_sel,
    input  logic [ddr_pkg::wb_dat_w-1:0]     wb_dat_w,
    input  logic                             wr_word,
    input  logic                             fill_beat,
    input  logic                             rd_beat,
    input  logic [ddr_pkg::app_data_w-1:0]   app_rd_data,
    input  logic                             set_valid_clean,
    input  logic                             set_dirty,
    input  logic                             use_victim_tag,
    input  logic                             beat_sel,
    output logic                             hit,
    output logic                             dirty,
    output logic [ddr_pkg::wb_dat_w-1:0]     wb_dat_r,
    output logic [ddr_pkg::tag_w-1:0]        line_addr,
    output logic [ddr_pkg::app_data_w-1:0]   beat_data
);

    logic [ddr_pkg::line_w-1:0]    line_q;
    logic [ddr_pkg::tag_w-1:0]     tag_q;
    logic                          valid_q;
    logic                          dirty_q;
    logic [ddr_pkg::tag_w-1:0]     req_tag;
    logic [ddr_pkg::word_bits-1:0] word_idx;

    assign req_tag = wb_adr[ddr_pkg::wb_adr_w-1:ddr_pkg::word_bits];
    assign word_idx = wb_adr[ddr_pkg::word_bits-1:0];

    assign hit = valid_q && (tag_q == req_tag);
    assign dirty = dirty_q;
    assign wb_dat_r = line_q[word_idx*ddr_pkg::wb_dat_w +: ddr_pkg::wb_dat_w];

    // Victim tag addresses the write-back, request tag the fill
    assign line_addr = use_victim_tag ? tag_q : req_tag;
    assign beat_data = line_q[beat_sel*ddr_pkg::app_data_w +: ddr_pkg::app_data_w];

    // ------------------------------
    // Line data and tag
    // ------------------------------
    always_ff @(posedge ui_clk) begin
        if (fill_beat) begin
            line_q[rd_beat*ddr_pkg::app_data_w +: ddr_pkg::app_data_w] <= app_rd_data;
        end
        if (wr_word) begin
            // Merge only the selected bytes
            for (int b = 0; b < ddr_pkg::sel_w; b++) begin
                if (wb_sel[b]) begin
                    line_q[word_idx*ddr_pkg::wb_dat_w + b*8 +: 8] <= wb_dat_w[b*8 +: 8];
                end
            end
        end
        if (set_valid_clean) begin
            tag_q <= req_tag;
        end
    end

    // ------------------------------
    // Line state
    // ------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else if (set_valid_clean) begin
            valid_q <= 1'b1;
            dirty_q <= 1'b0;
        end else if (set_dirty) begin
            dirty_q <= 1'b1;
        end
    end

endmodule

//--- source/app_port.sv
`timescale 1ns/1ps
// App port register driving one command and write beat until the core takes them
module app_port (
    input  logic                             ui_clk,
    input  logic                             rst,
    input  logic                             issue_beat,
    input  ddr_pkg::app_cmd_t                issue_cmd,
    input  logic                             beat_sel,
    input  logic [ddr_pkg::tag_w-1:0]        line_addr,
    input  logic [ddr_pkg::app_data_w-1:0]   beat_data,
    input  logic                             app_rdy,
    input  logic                             app_wdf_rdy,
    output logic                             app_en,
    output ddr_pkg::app_cmd_t                app_cmd,
    output logic [ddr_pkg::app_addr_w-1:0]   app_addr,
    output logic                             app_wdf_wren,
    output logic [ddr_pkg::app_data_w-1:0]   app_wdf_data,
    output logic                             app_wdf_end,
    output logic                             cmd_accept,
    output logic                             wdf_accept
);

    logic [ddr_pkg::app_addr_w-1:0] line_base;
    logic [ddr_pkg::app_addr_w-1:0] beat_addr;

    // Line base is tag times 32
    assign line_base = {{(ddr_pkg::app_addr_w - ddr_pkg::tag_w - ddr_pkg::line_shift){1'b0}},
                        line_addr, {ddr_pkg::line_shift{1'b0}}};
    assign beat_addr = line_base + (beat_sel ? ddr_pkg::beat_offset : '0);

    assign cmd_accept = app_en & app_rdy;
    assign wdf_accept = app_wdf_wren & app_wdf_rdy;

    // Each write is a single beat
    assign app_wdf_end = app_wdf_wren;

    // ------------------------------
    // Strobes
    // ------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            app_en <= 1'b0;
            app_wdf_wren <= 1'b0;
        end else if (issue_beat) begin
            app_en <= 1'b1;
            app_wdf_wren <= (issue_cmd == ddr_pkg::cmd_write);
        end else begin
            // Command and data are released independently
            if (cmd_accept) begin
                app_en <= 1'b0;
            end
            if (wdf_accept) begin
                app_wdf_wren <= 1'b0;
            end
        end
    end

    // Payload only changes on a new beat
    always_ff @(posedge ui_clk) begin
        if (issue_beat) begin
            app_cmd <= issue_cmd;
            app_addr <= beat_addr;
            app_wdf_data <= beat_data;
        end
    end

endmodule

//--- source/ddr_line_cache.sv
`timescale 1ns/1ps
// DDR line cache top joining the Wishbone slave port to the memory core app interface
module ddr_line_cache (
    input  logic                             ui_clk,
    input  logic                             rst,
    // Wishbone classic slave
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [ddr_pkg::wb_adr_w-1:0]     wb_adr,
    input  logic [ddr_pkg::sel_w-1:0]        wb_sel,
    input  logic [ddr_pkg::wb_dat_w-1:0]     wb_dat_w,
    output logic [ddr_pkg::wb_dat_w-1:0]     wb_dat_r,
    output logic                             wb_ack,
    // App interface
    output logic                             app_en,
    output ddr_pkg::app_cmd_t                app_cmd,
    output logic [ddr_pkg::app_addr_w-1:0]   app_addr,
    output logic                             app_wdf_wren,
    output logic [ddr_pkg::app_data_w-1:0]   app_wdf_data,
    output logic                             app_wdf_end,
    input  logic                             app_rdy,
    input  logic                             app_wdf_rdy,
    input  logic [ddr_pkg::app_data_w-1:0]   app_rd_data,
    input  logic                             app_rd_data_valid,
    input  logic                             init_calib_complete
);

    logic                           hit;
    logic                           dirty;
    logic                           issue_beat;
    ddr_pkg::app_cmd_t              issue_cmd;
    logic                           beat_sel;
    logic                           timer_clear;
    logic                           wr_word;
    logic                           set_valid_clean;
    logic                           set_dirty;
    logic                           use_victim_tag;
    logic                           cmd_accept;
    logic                           wdf_accept;
    logic                           cmds_done;
    logic                           wdata_done;
    logic                           rdata_done;
    logic                           rd_beat;
    logic [ddr_pkg::tag_w-1:0]      line_addr;
    logic [ddr_pkg::app_data_w-1:0] beat_data;

    line_fsm fsm0 (
        .ui_clk,
        .rst,
        .init_calib_complete,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .hit,
        .dirty,
        .cmd_accept,
        .wdf_accept,
        .cmds_done,
        .wdata_done,
        .rdata_done,
        .wb_ack,
        .issue_beat,
        .issue_cmd,
        .beat_sel,
        .timer_clear,
        .wr_word,
        .set_valid_clean,
        .set_dirty,
        .use_victim_tag
    );

    beat_timer timer0 (
        .ui_clk,
        .rst,
        .timer_clear,
        .cmd_accept,
        .wdf_accept,
        .app_rd_data_valid,
        .cmds_done,
        .wdata_done,
        .rdata_done,
        .rd_beat
    );

    // Every returning read beat fills half the line
    line_buffer buf0 (
        .ui_clk,
        .rst,
        .wb_adr,
        .wb_sel,
        .wb_dat_w,
        .wr_word,
        .fill_beat (app_rd_data_valid),
        .rd_beat,
        .app_rd_data,
        .set_valid_clean,
        .set_dirty,
        .use_victim_tag,
        .beat_sel,
        .hit,
        .dirty,
        .wb_dat_r,
        .line_addr,
        .beat_data
    );

    app_port port0 (
        .ui_clk,
        .rst,
        .issue_beat,
        .issue_cmd,
        .beat_sel,
        .line_addr,
        .beat_data,
        .app_rdy,
        .app_wdf_rdy,
        .app_en,
        .app_cmd,
        .app_addr,
        .app_wdf_wren,
        .app_wdf_data,
        .app_wdf_end,
        .cmd_accept,
        .wdf_accept
    );

endmodule

//--- tb/mig_app_model.sv
`timescale 1ns/1ps
// Behavioral app-interface memory with random ready, read latency and calibration delay
module mig_app_model (
    input  logic                             ui_clk,
    input  logic                             rst,
    input  logic                             app_en,
    input  ddr_pkg::app_cmd_t                app_cmd,
    input  logic [ddr_pkg::app_addr_w-1:0]   app_addr,
    input  logic                             app_wdf_wren,
    input  logic [ddr_pkg::app_data_w-1:0]   app_wdf_data,
    input  logic                             app_wdf_end,
    output logic                             app_rdy,
    output logic                             app_wdf_rdy,
    output logic [ddr_pkg::app_data_w-1:0]   app_rd_data,
    output logic                             app_rd_data_valid,
    output logic                             init_calib_complete
);

    localparam int calib_cycles = 30;
    localparam logic [31:0] init_key = 32'h5A3C_96E1;

    // Sparse word memory keyed by 32-bit word address
    logic [31:0] mem [bit [31:0]];
    logic [ddr_pkg::app_addr_w-1:0] wr_addr_q [$];
    logic [ddr_pkg::app_data_w-1:0] wr_data_q [$];
    logic [ddr_pkg::app_addr_w-1:0] rd_addr_q [$];
    int unsigned rd_due_q [$];
    logic [31:0] lfsr_q = 32'h3387;
    int unsigned cyc_cnt;
    int unsigned last_due;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] word_at(input bit [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ init_key;
    endfunction

    initial begin
        logic [ddr_pkg::app_data_w-1:0] rd_data;
        logic rd_vld;
        int unsigned lat;
        int unsigned due;
        bit [31:0] base;
        logic [ddr_pkg::app_data_w-1:0] wdata;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd_data = '0;
        app_rd_data_valid = 1'b0;
        init_calib_complete = 1'b0;
        rd_data = '0;
        forever begin
            @(posedge ui_clk);
            rd_vld = 1'b0;
            if (!rst) begin
                cyc_cnt = 0;
                last_due = 0;
                wr_addr_q.delete();
                wr_data_q.delete();
                rd_addr_q.delete();
                rd_due_q.delete();
            end else begin
                cyc_cnt++;
                if (app_en && app_rdy) begin
                    if (app_cmd == ddr_pkg::cmd_write) begin
                        wr_addr_q.push_back(app_addr);
                    end else begin
                        lat = (rand_bits(3) % 6) + 1;
                        due = cyc_cnt + lat;
                        // Keep returns in issue order and at most one per cycle
                        if (due <= last_due) begin
                            due = last_due + 1;
                        end
                        last_due = due;
                        rd_addr_q.push_back(app_addr);
                        rd_due_q.push_back(due);
                    end
                end
                if (app_wdf_wren && app_wdf_rdy && app_wdf_end) begin
                    wr_data_q.push_back(app_wdf_data);
                end
                // Pair write commands with their data beats
                while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                    base = 32'(wr_addr_q.pop_front() >> 2);
                    wdata = wr_data_q.pop_front();
                    for (int i = 0; i < 4; i++) begin
                        mem[base + 32'(i)] = wdata[i*32 +: 32];
                    end
                end
                if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc_cnt) begin
                    base = 32'(rd_addr_q.pop_front() >> 2);
                    void'(rd_due_q.pop_front());
                    for (int i = 0; i < 4; i++) begin
                        rd_data[i*32 +: 32] = word_at(base + 32'(i));
                    end
                    rd_vld = 1'b1;
                end
            end
            #1;
            init_calib_complete = (cyc_cnt > calib_cycles);
            app_rdy = init_calib_complete && (rand_bits(1) != 0);
            app_wdf_rdy = init_calib_complete && (rand_bits(1) != 0);
            app_rd_data = rd_data;
            app_rd_data_valid = rd_vld;
        end
    end

endmodule

//--- tb/ddr_cache_sva.sv
`timescale 1ns/1ps
// Handshake assertions for the Wishbone port and the app interface of the DDR line cache
module ddr_cache_sva (
    input  logic                             ui_clk,
    input  logic                             rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_ack,
    input  logic                             app_en,
    input  ddr_pkg::app_cmd_t                app_cmd,
    input  logic [ddr_pkg::app_addr_w-1:0]   app_addr,
    input  logic                             app_rdy,
    input  logic                             app_wdf_wren,
    input  logic [ddr_pkg::app_data_w-1:0]   app_wdf_data,
    input  logic                             app_wdf_rdy
);

    // Count of failed properties
    int fail_count = 0;

    // ------------------------------
    // App interface
    // ------------------------------
    cmd_held: assert property (@(posedge ui_clk) disable iff (!rst)
        (app_en && !app_rdy) |=> (app_en && $stable(app_cmd) && $stable(app_addr)))
        else begin
            $error("app command dropped or changed before app_rdy");
            fail_count++;
        end

    wdata_held: assert property (@(posedge ui_clk) disable iff (!rst)
        (app_wdf_wren && !app_wdf_rdy) |=> (app_wdf_wren && $stable(app_wdf_data)))
        else begin
            $error("app write data dropped or changed before app_wdf_rdy");
            fail_count++;
        end

    // ------------------------------
    // Wishbone and reset
    // ------------------------------
    ack_in_cycle: assert property (@(posedge ui_clk) disable iff (!rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack without wb_cyc and wb_stb");
            fail_count++;
        end

    ack_single: assert property (@(posedge ui_clk) disable iff (!rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for two cycles in a row");
            fail_count++;
        end

    // Strobes come out of reset low
    reset_quiet: assert property (@(posedge ui_clk)
        !rst |=> (!wb_ack && !app_en && !app_wdf_wren))
        else begin
            $error("wb_ack, app_en or app_wdf_wren high after reset");
            fail_count++;
        end

endmodule

bind ddr_line_cache ddr_cache_sva sva0 (
    .ui_clk,
    .rst,
    .wb_cyc,
    .wb_stb,
    .wb_ack,
    .app_en,
    .app_cmd,
    .app_addr,
    .app_rdy,
    .app_wdf_wren,
    .app_wdf_data,
    .app_wdf_rdy
);

//--- tb/ddr_cache_tb.sv
`timescale 1ns/1ps
// DDR line cache testbench with app memory model, Wishbone driver and reference memory
module ddr_cache_tb;

    localparam int n_directed = 13;
    localparam int n_random = 60;
    localparam int cycle_limit = 40 * (n_directed + n_random) + 200;
    localparam logic [31:0] init_key = 32'h5A3C_96E1;

    logic                           ui_clk;
    logic                           rst;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [ddr_pkg::wb_adr_w-1:0]   wb_adr;
    logic [ddr_pkg::sel_w-1:0]      wb_sel;
    logic [ddr_pkg::wb_dat_w-1:0]   wb_dat_w;
    logic [ddr_pkg::wb_dat_w-1:0]   wb_dat_r;
    logic                           wb_ack;
    logic                           app_en;
    ddr_pkg::app_cmd_t              app_cmd;
    logic [ddr_pkg::app_addr_w-1:0] app_addr;
    logic                           app_wdf_wren;
    logic [ddr_pkg::app_data_w-1:0] app_wdf_data;
    logic                           app_wdf_end;
    logic                           app_rdy;
    logic                           app_wdf_rdy;
    logic [ddr_pkg::app_data_w-1:0] app_rd_data;
    logic                           app_rd_data_valid;
    logic                           init_calib_complete;

    logic [31:0] ref_mem [bit [31:0]];
    logic [31:0] lfsr_q = 32'h3387;
    int check_errors = 0;
    int cycle_cnt = 0;

    ddr_line_cache dut0 (.*);
    mig_app_model mem0 (.*);

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_word(input logic [ddr_pkg::wb_adr_w-1:0] adr);
        if (ref_mem.exists(32'(adr))) begin
            return ref_mem[32'(adr)];
        end
        return 32'(adr) ^ init_key;
    endfunction

    // One Wishbone classic access that leaves the strobe up for the next one
    // Waits counts negedges up to the ack
    task automatic wb_access(input logic we, input logic [ddr_pkg::wb_adr_w-1:0] adr,
                             input logic [ddr_pkg::sel_w-1:0] sel,
                             input logic [ddr_pkg::wb_dat_w-1:0] dat,
                             output logic [ddr_pkg::wb_dat_w-1:0] rdata, output int waits);
        waits = 0;
        @(posedge ui_clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_sel = sel;
        wb_dat_w = dat;
        do begin
            @(negedge ui_clk);
            waits++;
        end while (!wb_ack);
        rdata = wb_dat_r;
    endtask

    // Drops the strobe after the last acknowledged access
    task automatic bus_release();
        @(posedge ui_clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic read_check(input logic [ddr_pkg::wb_adr_w-1:0] adr, output int waits);
        logic [ddr_pkg::wb_dat_w-1:0] rdata;
        logic [ddr_pkg::wb_dat_w-1:0] expected;
        expected = ref_word(adr);
        wb_access(1'b0, adr, '1, '0, rdata, waits);
        assert (rdata === expected) else begin
            $display("** Error at %0t: read %h returned %h, expected %h",
                     $time, adr, rdata, expected);
            check_errors++;
        end
    endtask

    task automatic write_word(input logic [ddr_pkg::wb_adr_w-1:0] adr,
                              input logic [ddr_pkg::sel_w-1:0] sel,
                              input logic [ddr_pkg::wb_dat_w-1:0] dat);
        logic [ddr_pkg::wb_dat_w-1:0] rdata;
        logic [ddr_pkg::wb_dat_w-1:0] merged;
        int waits;
        wb_access(1'b1, adr, sel, dat, rdata, waits);
        merged = ref_word(adr);
        for (int b = 0; b < ddr_pkg::sel_w; b++) begin
            if (sel[b]) begin
                merged[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        ref_mem[32'(adr)] = merged;
    endtask

    // Nothing may be acknowledged before calibration
    always @(negedge ui_clk) begin
        assert (!(wb_ack && !init_calib_complete)) else begin
            $display("** Error at %0t: wb_ack before init_calib_complete", $time);
            check_errors++;
        end
    end

    always @(posedge ui_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Run hung: tests did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int waits;
        logic [ddr_pkg::wb_adr_w-1:0] adr;
        logic [ddr_pkg::wb_dat_w-1:0] dat;
        logic [ddr_pkg::sel_w-1:0] sel;
        logic we;
        rst = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat_w = '0;
        repeat (2) @(posedge ui_clk);
        #1;
        rst = 1'b1;

        // Issued while calibration is still running
        read_check(24'h000010, waits);
        read_check(24'h000013, waits);
        assert (waits == 2) else begin
            $display("** Error at %0t: hit acked after %0d cycles, expected 2", $time, waits);
            check_errors++;
        end
        bus_release();

        // ------------------------------
        // Byte-select merges
        // ------------------------------
        write_word(24'h000011, 4'b0001, 32'hA1B2_C3D4);
        write_word(24'h000012, 4'b0110, 32'h1357_9BDF);
        write_word(24'h000014, 4'b1000, 32'hFEDC_BA98);
        write_word(24'h000017, 4'b1111, 32'h0F1E_2D3C);
        read_check(24'h000011, waits);
        read_check(24'h000012, waits);
        read_check(24'h000014, waits);
        read_check(24'h000017, waits);
        bus_release();

        // Other line forces write-back of the dirty one
        read_check(24'h001230, waits);
        read_check(24'h000011, waits);
        read_check(24'h000017, waits);
        bus_release();

        // ------------------------------
        // Random traffic over four lines
        // ------------------------------
        for (int i = 0; i < n_random; i++) begin
            adr = 24'h000800 + 24'(rand_bits(2) * 32'h40);
            adr = adr + 24'(rand_bits(3));
            we = (rand_bits(1) != 0);
            if (we) begin
                sel = 4'(rand_bits(4));
                dat = rand_bits(32);
                write_word(adr, sel, dat);
            end else begin
                read_check(adr, waits);
            end
            if (rand_bits(1) != 0) begin
                bus_release();
            end
        end
        bus_release();

        $display("Error counts: %0d check errors, %0d assertion failures",
                 check_errors, dut0.sva0.fail_count);
        if (check_errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
source/ddr_pkg.sv
source/line_fsm.sv
source/beat_timer.sv
source/line_buffer.sv
source/app_port.sv
source/ddr_line_cache.sv
tb/mig_app_model.sv
tb/ddr_cache_sva.sv
tb/ddr_cache_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the DDR line cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module ddr_cache_tb -f build.f -o ddr_cache_sim
status=0
./obj_dir/ddr_cache_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
